//--- src/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// first fetch address after reset
`define RESET_PC    64'h0

// major opcodes
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011
`define OP_LUI      7'b0110111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// funct3 values
`define F3_ADD      3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_SW       3'b010
`define F3_SD       3'b011
`define F3_LD       3'b011

`endif

//--- src/riscv_pkg.sv
package riscv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  wmask_t;

    // alu control taken from funct7/funct3 in decode
    typedef struct packed {
        logic sub;
        logic pass_b;
        logic use_f3;
    } alu_sel_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     imm;
        reg_addr_t rd;
        logic      reg_wen;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jal;
        alu_sel_t  alu_sel;
        logic [2:0] funct3;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      reg_wen;
        logic      is_load;
        xlen_t     result;
    } ex_wb_t;

endpackage

//--- src/fetch.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module fetch (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                redirect_i,
    input  riscv_pkg::xlen_t    redirect_pc_i,
    input  riscv_pkg::inst_t    inst_i,
    output riscv_pkg::xlen_t    inst_addr_o,
    output riscv_pkg::if_id_t   if_id_o
);

    riscv_pkg::xlen_t pc;

    // instruction memory answers in the same cycle
    assign inst_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= `RESET_PC;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else begin
            pc <= pc + 64'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            if_id_o.valid <= 1'b0;
        end else if (redirect_i) begin
            // word fetched this cycle is on the wrong path
            if_id_o.valid <= 1'b0;
        end else begin
            if_id_o.valid <= 1'b1;
            if_id_o.pc    <= pc;
            if_id_o.inst  <= inst_i;
        end
    end

endmodule

//--- src/regs.sv
`timescale 1ns/100ps

module regs (
    input  logic                  clk,
    input  logic                  rst_i,
    input  riscv_pkg::reg_addr_t  rs1_addr_i,
    input  riscv_pkg::reg_addr_t  rs2_addr_i,
    output riscv_pkg::xlen_t      rs1_data_o,
    output riscv_pkg::xlen_t      rs2_data_o,
    input  riscv_pkg::reg_addr_t  rd_addr_i,
    input  riscv_pkg::xlen_t      rd_data_i,
    input  logic                  rd_wen_i
);

    // x1..x31, x0 has no storage
    riscv_pkg::xlen_t rf [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rd_wen_i && rd_addr_i != 5'd0) begin
            rf[rd_addr_i] <= rd_data_i;
        end
    end

    // write-through so decode sees the value retiring this cycle
    function automatic riscv_pkg::xlen_t read_port(input riscv_pkg::reg_addr_t addr);
        riscv_pkg::xlen_t val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (rd_wen_i && addr == rd_addr_i) begin
            val = rd_data_i;
        end else begin
            val = rf[addr];
        end
        return val;
    endfunction

    always_comb rs1_data_o = read_port(rs1_addr_i);
    always_comb rs2_data_o = read_port(rs2_addr_i);

endmodule

//--- src/id.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module id (
    input  logic                  clk,
    input  logic                  rst_i,
    input  riscv_pkg::if_id_t     if_id_i,
    input  logic                  flush_i,
    output riscv_pkg::reg_addr_t  rs1_addr_o,
    output riscv_pkg::reg_addr_t  rs2_addr_o,
    input  riscv_pkg::xlen_t      rs1_data_i,
    input  riscv_pkg::xlen_t      rs2_data_i,
    output riscv_pkg::id_ex_t     id_ex_o
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    riscv_pkg::reg_addr_t rd;
    logic                 f3_alu;
    riscv_pkg::xlen_t     imm_i;
    riscv_pkg::xlen_t     imm_s;
    riscv_pkg::xlen_t     imm_b;
    riscv_pkg::xlen_t     imm_j;
    riscv_pkg::xlen_t     imm_u;
    riscv_pkg::id_ex_t    id_ex_d;

    assign opcode     = if_id_i.inst[6:0];
    assign rd         = if_id_i.inst[11:7];
    assign funct3     = if_id_i.inst[14:12];
    assign funct7     = if_id_i.inst[31:25];
    assign rs1_addr_o = if_id_i.inst[19:15];
    assign rs2_addr_o = if_id_i.inst[24:20];

    assign f3_alu = (funct3 == `F3_ADD) || (funct3 == `F3_XOR) ||
                    (funct3 == `F3_OR)  || (funct3 == `F3_AND);

    // sign-extended immediates
    assign imm_i = {{52{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
    assign imm_s = {{52{if_id_i.inst[31]}}, if_id_i.inst[31:25], if_id_i.inst[11:7]};
    assign imm_b = {{52{if_id_i.inst[31]}}, if_id_i.inst[7], if_id_i.inst[30:25],
                    if_id_i.inst[11:8], 1'b0};
    assign imm_j = {{44{if_id_i.inst[31]}}, if_id_i.inst[19:12], if_id_i.inst[20],
                    if_id_i.inst[30:21], 1'b0};
    assign imm_u = {{32{if_id_i.inst[31]}}, if_id_i.inst[31:12], 12'b0};

    always_comb begin
        id_ex_d        = '0;
        id_ex_d.valid  = if_id_i.valid;
        id_ex_d.pc     = if_id_i.pc;
        id_ex_d.op1    = rs1_data_i;
        id_ex_d.op2    = rs2_data_i;
        id_ex_d.rd     = rd;
        id_ex_d.funct3 = funct3;
        case (opcode)
            `OP_IMM: begin
                if (f3_alu) begin
                    id_ex_d.reg_wen        = 1'b1;
                    id_ex_d.imm            = imm_i;
                    id_ex_d.op2            = imm_i;
                    id_ex_d.alu_sel.use_f3 = 1'b1;
                end
            end
            `OP_REG: begin
                // only sub uses the alternate funct7
                if (f3_alu && (funct7 == 7'b0 ||
                               (funct7 == 7'b0100000 && funct3 == `F3_ADD))) begin
                    id_ex_d.reg_wen        = 1'b1;
                    id_ex_d.alu_sel.use_f3 = 1'b1;
                    id_ex_d.alu_sel.sub    = funct7[5];
                end
            end
            `OP_LUI: begin
                id_ex_d.reg_wen        = 1'b1;
                id_ex_d.imm            = imm_u;
                id_ex_d.op2            = imm_u;
                id_ex_d.alu_sel.pass_b = 1'b1;
            end
            `OP_LOAD: begin
                if (funct3 == `F3_LD) begin
                    id_ex_d.is_load = 1'b1;
                    id_ex_d.reg_wen = 1'b1;
                    id_ex_d.imm     = imm_i;
                end
            end
            `OP_STORE: begin
                if (funct3 == `F3_SW || funct3 == `F3_SD) begin
                    id_ex_d.is_store = 1'b1;
                    id_ex_d.imm      = imm_s;
                end
            end
            `OP_BRANCH: begin
                if (funct3 == `F3_BEQ || funct3 == `F3_BNE) begin
                    id_ex_d.is_branch = 1'b1;
                    id_ex_d.imm       = imm_b;
                end
            end
            `OP_JAL: begin
                id_ex_d.is_jal  = 1'b1;
                id_ex_d.reg_wen = 1'b1;
                id_ex_d.imm     = imm_j;
            end
            default: ;
        endcase
        // x0 is never written
        if (rd == 5'd0) begin
            id_ex_d.reg_wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

//--- src/ex.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module ex (
    input  riscv_pkg::id_ex_t   id_ex_i,
    output riscv_pkg::ex_wb_t   ex_wb_o,
    output logic                redirect_o,
    output riscv_pkg::xlen_t    redirect_pc_o,
    output logic                mem_ren_o,
    output riscv_pkg::xlen_t    mem_raddr_o,
    output logic                mem_wen_o,
    output riscv_pkg::xlen_t    mem_waddr_o,
    output riscv_pkg::xlen_t    mem_wdata_o,
    output riscv_pkg::wmask_t   mem_wmask_o
);

    riscv_pkg::xlen_t alu_res;
    riscv_pkg::xlen_t mem_addr;
    logic             equal;
    logic             br_taken;

    always_comb begin
        alu_res = id_ex_i.op1 + id_ex_i.op2;
        if (id_ex_i.alu_sel.pass_b) begin
            // lui
            alu_res = id_ex_i.op2;
        end else if (id_ex_i.alu_sel.use_f3) begin
            case (id_ex_i.funct3)
                `F3_ADD: alu_res = id_ex_i.alu_sel.sub ? id_ex_i.op1 - id_ex_i.op2
                                                       : id_ex_i.op1 + id_ex_i.op2;
                `F3_XOR: alu_res = id_ex_i.op1 ^ id_ex_i.op2;
                `F3_OR:  alu_res = id_ex_i.op1 | id_ex_i.op2;
                `F3_AND: alu_res = id_ex_i.op1 & id_ex_i.op2;
                default: alu_res = id_ex_i.op1 + id_ex_i.op2;
            endcase
        end
    end

    // branch compare and redirect
    assign equal         = (id_ex_i.op1 == id_ex_i.op2);
    assign br_taken      = id_ex_i.is_branch &&
                           ((id_ex_i.funct3 == `F3_BNE) ? !equal : equal);
    assign redirect_o    = id_ex_i.valid && (br_taken || id_ex_i.is_jal);
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    // data memory request
    assign mem_addr    = id_ex_i.op1 + id_ex_i.imm;
    assign mem_ren_o   = id_ex_i.valid && id_ex_i.is_load;
    assign mem_raddr_o = mem_addr;
    assign mem_wen_o   = id_ex_i.valid && id_ex_i.is_store;
    assign mem_waddr_o = {mem_addr[63:3], 3'b000};

    always_comb begin
        mem_wdata_o = '0;
        mem_wmask_o = '0;
        if (mem_wen_o) begin
            if (id_ex_i.funct3 == `F3_SD) begin
                mem_wdata_o = id_ex_i.op2;
                mem_wmask_o = 8'hff;
            end else if (mem_addr[2]) begin
                mem_wdata_o = {id_ex_i.op2[31:0], 32'b0};
                mem_wmask_o = 8'hf0;
            end else begin
                mem_wdata_o = {32'b0, id_ex_i.op2[31:0]};
                mem_wmask_o = 8'h0f;
            end
        end
    end

    // jal links pc + 4
    assign ex_wb_o.valid   = id_ex_i.valid;
    assign ex_wb_o.rd      = id_ex_i.rd;
    assign ex_wb_o.reg_wen = id_ex_i.reg_wen;
    assign ex_wb_o.is_load = id_ex_i.is_load;
    assign ex_wb_o.result  = id_ex_i.is_jal ? id_ex_i.pc + 64'd4 : alu_res;

endmodule

//--- src/wb.sv
`timescale 1ns/100ps

module wb (
    input  logic                  clk,
    input  logic                  rst_i,
    input  riscv_pkg::ex_wb_t     ex_wb_i,
    input  riscv_pkg::xlen_t      mem_rdata_i,
    output riscv_pkg::reg_addr_t  rd_addr_o,
    output riscv_pkg::xlen_t      rd_data_o,
    output logic                  rd_wen_o
);

    riscv_pkg::ex_wb_t ex_wb_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_wb_q <= '0;
        end else begin
            ex_wb_q <= ex_wb_i;
        end
    end

    assign rd_addr_o = ex_wb_q.rd;
    // load data shows up one cycle after the request
    assign rd_data_o = ex_wb_q.is_load ? mem_rdata_i : ex_wb_q.result;
    assign rd_wen_o  = ex_wb_q.valid && ex_wb_q.reg_wen;

endmodule

//--- src/riscv.sv
`timescale 1ns/100ps

module riscv (
    input  logic                clk,
    input  logic                rst_i,
    input  riscv_pkg::inst_t    inst_i,
    output riscv_pkg::xlen_t    inst_addr_o,
    input  riscv_pkg::xlen_t    mem_rdata_i,
    output logic                mem_ren_o,
    output riscv_pkg::xlen_t    mem_raddr_o,
    output logic                mem_wen_o,
    output riscv_pkg::xlen_t    mem_waddr_o,
    output riscv_pkg::xlen_t    mem_wdata_o,
    output riscv_pkg::wmask_t   mem_wmask_o
);

    riscv_pkg::if_id_t    if_id;
    riscv_pkg::id_ex_t    id_ex;
    riscv_pkg::ex_wb_t    ex_wb;
    logic                 redirect;
    riscv_pkg::xlen_t     redirect_pc;
    riscv_pkg::reg_addr_t rs1_addr;
    riscv_pkg::reg_addr_t rs2_addr;
    riscv_pkg::xlen_t     rs1_data;
    riscv_pkg::xlen_t     rs2_data;
    riscv_pkg::reg_addr_t rd_addr;
    riscv_pkg::xlen_t     rd_data;
    logic                 rd_wen;

    fetch fetch_inst (
        .clk           ( clk         ),
        .rst_i         ( rst_i       ),
        .redirect_i    ( redirect    ),
        .redirect_pc_i ( redirect_pc ),
        .inst_i        ( inst_i      ),
        .inst_addr_o   ( inst_addr_o ),
        .if_id_o       ( if_id       )
    );

    regs regs_inst (
        .clk        ( clk      ),
        .rst_i      ( rst_i    ),
        .rs1_addr_i ( rs1_addr ),
        .rs2_addr_i ( rs2_addr ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data ),
        .rd_addr_i  ( rd_addr  ),
        .rd_data_i  ( rd_data  ),
        .rd_wen_i   ( rd_wen   )
    );

    id id_inst (
        .clk        ( clk      ),
        .rst_i      ( rst_i    ),
        .if_id_i    ( if_id    ),
        .flush_i    ( redirect ),
        .rs1_addr_o ( rs1_addr ),
        .rs2_addr_o ( rs2_addr ),
        .rs1_data_i ( rs1_data ),
        .rs2_data_i ( rs2_data ),
        .id_ex_o    ( id_ex    )
    );

    // execute also drives the data memory ports
    ex ex_inst (
        .id_ex_i       ( id_ex       ),
        .ex_wb_o       ( ex_wb       ),
        .redirect_o    ( redirect    ),
        .redirect_pc_o ( redirect_pc ),
        .mem_ren_o     ( mem_ren_o   ),
        .mem_raddr_o   ( mem_raddr_o ),
        .mem_wen_o     ( mem_wen_o   ),
        .mem_waddr_o   ( mem_waddr_o ),
        .mem_wdata_o   ( mem_wdata_o ),
        .mem_wmask_o   ( mem_wmask_o )
    );

    wb wb_inst (
        .clk         ( clk         ),
        .rst_i       ( rst_i       ),
        .ex_wb_i     ( ex_wb       ),
        .mem_rdata_i ( mem_rdata_i ),
        .rd_addr_o   ( rd_addr     ),
        .rd_data_o   ( rd_data     ),
        .rd_wen_o    ( rd_wen      )
    );

endmodule

//--- sim/riscv_assert.sv
`timescale 1ns/100ps

module riscv_assert (
    input logic                clk,
    input logic                rst_i,
    input riscv_pkg::xlen_t    inst_addr_o,
    input logic                mem_ren_o,
    input logic                mem_wen_o,
    input riscv_pkg::wmask_t   mem_wmask_o
);

    // one data access per cycle
    a_no_read_write: assert property (@(posedge clk) disable iff (rst_i)
        !(mem_ren_o && mem_wen_o))
        else $error("data memory read and write requested together");

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(rst_i) |-> (!mem_ren_o && !mem_wen_o))
        else $error("data memory request in the first cycle after reset");

    a_fetch_aligned: assert property (@(posedge clk) disable iff (rst_i)
        inst_addr_o[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    // a store always writes some byte
    a_store_mask: assert property (@(posedge clk) disable iff (rst_i)
        mem_wen_o |-> mem_wmask_o != 8'h00)
        else $error("store with an empty byte mask");

endmodule

bind riscv riscv_assert riscv_assert_inst (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .inst_addr_o ( inst_addr_o ),
    .mem_ren_o   ( mem_ren_o   ),
    .mem_wen_o   ( mem_wen_o   ),
    .mem_wmask_o ( mem_wmask_o )
);

//--- sim/tb_riscv.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module tb_riscv;

    typedef struct packed {
        riscv_pkg::xlen_t  addr;
        riscv_pkg::xlen_t  data;
        riscv_pkg::wmask_t mask;
    } store_rec_t;

    logic              clk;
    logic              rst_i;
    riscv_pkg::inst_t  inst_i;
    riscv_pkg::xlen_t  inst_addr_o;
    riscv_pkg::xlen_t  mem_rdata_i;
    logic              mem_ren_o;
    riscv_pkg::xlen_t  mem_raddr_o;
    logic              mem_wen_o;
    riscv_pkg::xlen_t  mem_waddr_o;
    riscv_pkg::xlen_t  mem_wdata_o;
    riscv_pkg::wmask_t mem_wmask_o;

    riscv_pkg::inst_t  imem [64];
    riscv_pkg::xlen_t  dmem [64];
    riscv_pkg::inst_t  prog [$];
    store_rec_t        stores [$];
    riscv_pkg::xlen_t  load_addrs [$];
    logic              rd_pend;
    riscv_pkg::xlen_t  rd_data;
    int                errors;
    int                failures;
    integer            seed;

    riscv DUT (
        .clk         ( clk         ),
        .rst_i       ( rst_i       ),
        .inst_i      ( inst_i      ),
        .inst_addr_o ( inst_addr_o ),
        .mem_rdata_i ( mem_rdata_i ),
        .mem_ren_o   ( mem_ren_o   ),
        .mem_raddr_o ( mem_raddr_o ),
        .mem_wen_o   ( mem_wen_o   ),
        .mem_waddr_o ( mem_waddr_o ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_wmask_o ( mem_wmask_o )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction encoders for the RV64I base formats
    function automatic riscv_pkg::inst_t enc_i(input logic [11:0] imm,
            input riscv_pkg::reg_addr_t rs1, input logic [2:0] f3,
            input riscv_pkg::reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscv_pkg::inst_t enc_r(input logic [6:0] f7,
            input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input riscv_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic riscv_pkg::inst_t enc_s(input logic [11:0] imm,
            input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1,
            input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic riscv_pkg::inst_t enc_b(input logic [12:0] off,
            input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1,
            input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic riscv_pkg::inst_t enc_j(input logic [20:0] off,
            input riscv_pkg::reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic riscv_pkg::inst_t enc_u(input logic [19:0] imm,
            input riscv_pkg::reg_addr_t rd);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic riscv_pkg::xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic riscv_pkg::xlen_t bit_mask(input riscv_pkg::wmask_t m);
        riscv_pkg::xlen_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = {8{m[i]}};
        end
        return r;
    endfunction

    task automatic check_xlen(input riscv_pkg::xlen_t got, input riscv_pkg::xlen_t exp,
            input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input riscv_pkg::xlen_t got, input riscv_pkg::xlen_t exp,
            input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input riscv_pkg::wmask_t got, input riscv_pkg::wmask_t exp,
            input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one cycle of both memory models
    // inputs change on the falling edge
    task automatic tick();
        int idx;
        @(negedge clk);
        if (rd_pend) begin
            mem_rdata_i = rd_data;
        end
        rd_pend = mem_ren_o;
        rd_data = dmem[mem_raddr_o[8:3]];
        if (mem_ren_o) begin
            load_addrs.push_back(mem_raddr_o);
        end
        if (mem_wen_o) begin
            stores.push_back('{addr: mem_waddr_o, data: mem_wdata_o, mask: mem_wmask_o});
            idx = int'(mem_waddr_o[8:3]);
            for (int b = 0; b < 8; b++) begin
                if (mem_wmask_o[b]) begin
                    dmem[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                end
            end
        end
        inst_i = imem[inst_addr_o[7:2]];
    endtask

    // assemble prog into imem and reset the core on it
    task automatic run_program();
        rst_i = 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : enc_j(21'd0, 5'd0);
            dmem[i] = {32'hc0de_0000 + 32'(i), ~32'(i)};
        end
        repeat (5) begin
            tick();
            if (mem_ren_o || mem_wen_o) begin
                failures++;
                $display("Data memory enable was high during reset at %0t", $time);
            end
        end
        rst_i = 1'b0;
        rd_pend = 1'b0;
        stores.delete();
        load_addrs.delete();
    endtask

    task automatic wait_stores(input int n);
        int cycles;
        cycles = 0;
        while (stores.size() < n && cycles < 200) begin
            tick();
            cycles++;
        end
        if (stores.size() < n) begin
            failures++;
            $display("Timed out waiting for %0d stores, only %0d seen", n, stores.size());
        end
        // no store may follow the last expected one
        repeat (8) tick();
        if (stores.size() != n) begin
            errors++;
            $display("Mismatch at %0t: store count is %0d, expected %0d", $time,
                     stores.size(), n);
        end
    endtask

    task automatic check_store(input int n, input riscv_pkg::xlen_t addr,
            input riscv_pkg::xlen_t data, input riscv_pkg::wmask_t mask);
        store_rec_t rec;
        if (n >= stores.size()) begin
            return;
        end
        rec = stores[n];
        check_addr(rec.addr, addr, "store address");
        check_mask(rec.mask, mask, "store mask");
        check_xlen(rec.data & bit_mask(mask), data, "store data");
    endtask

    task automatic test_reset();
        prog.delete();
        // loads and stores back to back so both enables are busy when reset hits
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0) begin
                prog.push_back(enc_i(12'(8 * i), 5'd0, `F3_LD, 5'd0, `OP_LOAD));
            end else begin
                prog.push_back(enc_s(12'(8 * i), 5'd0, 5'd0, `F3_SD));
            end
        end
        run_program();
        repeat (4) tick();
        prog.delete();
        for (int i = 0; i < 16; i++) begin
            prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        end
        run_program();
        check_addr(inst_addr_o, `RESET_PC, "first fetch address");
        for (int k = 1; k <= 5; k++) begin
            tick();
            check_addr(inst_addr_o, `RESET_PC + 64'(4 * k), "fetch address");
        end
    endtask

    task automatic test_alu();
        logic [11:0]      a;
        logic [11:0]      b;
        logic [19:0]      u;
        riscv_pkg::xlen_t va;
        riscv_pkg::xlen_t vb;
        a  = 12'($random(seed));
        b  = 12'($random(seed));
        u  = 20'($random(seed));
        va = sext12(a);
        vb = sext12(b);
        prog.delete();
        prog.push_back(enc_i(a, 5'd0, `F3_ADD, 5'd1, `OP_IMM));
        prog.push_back(enc_i(b, 5'd0, `F3_ADD, 5'd2, `OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd3));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, `F3_ADD, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, `F3_AND, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, `F3_OR, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, `F3_XOR, 5'd7));
        prog.push_back(enc_u(u, 5'd8));
        for (int r = 3; r <= 8; r++) begin
            prog.push_back(enc_s(12'(8 * (r - 3)), 5'(r), 5'd0, `F3_SD));
        end
        prog.push_back(enc_s(12'd48, 5'd1, 5'd0, `F3_SD));
        run_program();
        wait_stores(7);
        check_store(0, 64'd0, va + vb, 8'hff);
        check_store(1, 64'd8, va - vb, 8'hff);
        check_store(2, 64'd16, va & vb, 8'hff);
        check_store(3, 64'd24, va | vb, 8'hff);
        check_store(4, 64'd32, va ^ vb, 8'hff);
        check_store(5, 64'd40, {{32{u[19]}}, u, 12'h000}, 8'hff);
        check_store(6, 64'd48, va, 8'hff);
    endtask

    task automatic test_load();
        riscv_pkg::xlen_t v;
        v = {32'($random(seed)), 32'($random(seed))};
        prog.delete();
        prog.push_back(enc_i(12'd32, 5'd0, `F3_ADD, 5'd2, `OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_i(12'd8, 5'd2, `F3_LD, 5'd1, `OP_LOAD));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_s(12'd48, 5'd1, 5'd2, `F3_SD));
        run_program();
        dmem[5] = v;
        wait_stores(1);
        if (load_addrs.size() != 1) begin
            errors++;
            $display("Mismatch at %0t: load count is %0d, expected 1", $time,
                     load_addrs.size());
        end else begin
            check_addr(load_addrs[0], 64'd40, "load address");
        end
        check_store(0, 64'd80, v, 8'hff);
    endtask

    task automatic test_store_width();
        logic [11:0]      a;
        logic [19:0]      u;
        riscv_pkg::xlen_t v;
        a = 12'($random(seed));
        u = 20'($random(seed));
        v = {{32{u[19]}}, u, 12'h000} + sext12(a);
        prog.delete();
        prog.push_back(enc_u(u, 5'd1));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_i(a, 5'd1, `F3_ADD, 5'd1, `OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_s(12'd64, 5'd1, 5'd0, `F3_SW));
        prog.push_back(enc_s(12'd76, 5'd1, 5'd0, `F3_SW));
        prog.push_back(enc_s(12'd88, 5'd1, 5'd0, `F3_SD));
        run_program();
        wait_stores(3);
        check_store(0, 64'd64, {32'h0, v[31:0]}, 8'h0f);
        check_store(1, 64'd72, {v[31:0], 32'h0}, 8'hf0);
        check_store(2, 64'd88, v, 8'hff);
    endtask

    task automatic test_control_flow();
        prog.delete();
        prog.push_back(enc_i(12'd5, 5'd0, `F3_ADD, 5'd1, `OP_IMM));
        prog.push_back(enc_i(12'd5, 5'd0, `F3_ADD, 5'd2, `OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_b(13'd16, 5'd2, 5'd1, `F3_BEQ));
        // beq shadow and skipped slot
        prog.push_back(enc_s(12'd0, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_s(12'd8, 5'd2, 5'd0, `F3_SD));
        prog.push_back(enc_s(12'd16, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_s(12'd24, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_b(13'd16, 5'd2, 5'd1, `F3_BNE));
        prog.push_back(enc_s(12'd32, 5'd0, 5'd0, `F3_SD));
        prog.push_back(enc_s(12'd40, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_j(21'd16, 5'd3));
        prog.push_back(enc_s(12'd48, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_s(12'd56, 5'd1, 5'd0, `F3_SD));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_i(12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM));
        prog.push_back(enc_s(12'd64, 5'd3, 5'd0, `F3_SD));
        run_program();
        wait_stores(4);
        check_store(0, 64'd24, 64'd5, 8'hff);
        check_store(1, 64'd32, 64'd0, 8'hff);
        check_store(2, 64'd40, 64'd5, 8'hff);
        // jal sits at word 11
        check_store(3, 64'd64, 64'd44 + 64'd4, 8'hff);
    endtask

    initial begin
        seed        = 32'h20ff;
        errors      = 0;
        failures    = 0;
        rst_i       = 1'b1;
        inst_i      = '0;
        mem_rdata_i = '0;
        rd_pend     = 1'b0;
        rd_data     = '0;
        test_reset();
        test_alu();
        test_load();
        test_store_width();
        test_control_flow();
        $display("mismatches: %0d, other failures: %0d", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/riscv_pkg.sv
src/fetch.sv
src/regs.sv
src/id.sv
src/ex.sv
src/wb.sv
src/riscv.sv
sim/riscv_assert.sv
sim/tb_riscv.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_riscv \
    -Mdir obj_dir -o sim_riscv \
    && ./obj_dir/sim_riscv | tee /dev/stderr | grep -q "All tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
